// ==== rtl/cpu7_pkg.sv ====
// sizes, address map, word types, opcodes, sequencer states and bus structs for cpu7

`default_nettype none

package cpu7_pkg;

	localparam int cores = 4;
	localparam int core_idx_w = $clog2(cores);
	localparam int program_words = 256;
	localparam int region_words = program_words / cores; // one region per core
	localparam int stack_depth = 8;
	localparam int stack_idx_w = $clog2(stack_depth);
	localparam int sp_w = $clog2(stack_depth + 1); // holds 0..stack_depth
	localparam int pc_w = 8;
	localparam int value_w = 32;
	localparam int word_w = 16;
	localparam int payload_w = 14;
	localparam int shift_w = $clog2(value_w) + 1;

	// apb address map
	localparam int apb_addr_w = 12;
	localparam logic [apb_addr_w-1:0] addr_ctrl = 12'h800; // also end of program window
	localparam logic [apb_addr_w-1:0] addr_status = 12'h804;
	localparam logic [apb_addr_w-1:0] addr_out_base = 12'h810;

	// top two bits of every program word
	typedef enum logic [1:0] {
		wt_dnl = 2'b00, // data, more words follow
		wt_dat = 2'b01, // data, last word, push
		wt_cpu = 2'b10, // instruction in payload[3:0]
		wt_ign = 2'b11
	} word_type_e;

	typedef enum logic [3:0] {
		op_nop,
		op_add,
		op_sub,
		op_and,
		op_xor,
		op_dup,
		op_drop,
		op_swap,
		op_out,
		op_halt
	} opcode_e;

	typedef enum logic [2:0] {
		s_idle,
		s_start,
		s_before_read,
		s_read_word,
		s_decode_word,
		s_wait_core,
		s_next_core
	} seq_state_e;

	// broadcast to all cores, only the enabled one acts
	typedef struct packed {
		logic push_en;
		logic instr_en;
		logic [value_w-1:0] push_value;
		opcode_e opcode;
	} core_cmd_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/program_ram.sv ====
// program word memory, one write port, async read ports for sequencer and host

`default_nettype none

module program_ram (
	input wire logic clk,
	input wire logic we,
	input wire logic [cpu7_pkg::pc_w-1:0] waddr,
	input wire logic [cpu7_pkg::word_w-1:0] wdata,
	input wire logic [cpu7_pkg::pc_w-1:0] raddr,
	output logic [cpu7_pkg::word_w-1:0] rdata,
	input wire logic [cpu7_pkg::pc_w-1:0] host_raddr,
	output logic [cpu7_pkg::word_w-1:0] host_rdata
);

	logic [cpu7_pkg::word_w-1:0] mem [cpu7_pkg::program_words];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata = mem[raddr]; // sequencer fetch
	assign host_rdata = mem[host_raddr]; // apb readback

endmodule

`default_nettype wire

// ==== rtl/stack_core.sv ====
// stack core: program pointer, data stack, alu and output register

`default_nettype none

module stack_core #(
	parameter int core_index = 0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic en,
	input wire logic restart,
	input wire logic step,
	input wire cpu7_pkg::core_cmd_t cmd,
	output logic [cpu7_pkg::pc_w-1:0] pc,
	output logic idle,
	output logic halted,
	output logic [cpu7_pkg::value_w-1:0] out_value
);

	logic [cpu7_pkg::value_w-1:0] stack [cpu7_pkg::stack_depth];
	logic [cpu7_pkg::sp_w-1:0] sp; // number of entries
	logic [cpu7_pkg::stack_idx_w-1:0] top_idx;
	logic [cpu7_pkg::stack_idx_w-1:0] sec_idx;
	logic [cpu7_pkg::stack_idx_w-1:0] push_idx;
	logic [cpu7_pkg::stack_idx_w-1:0] res_idx;
	logic [cpu7_pkg::value_w-1:0] top;
	logic [cpu7_pkg::value_w-1:0] second;
	logic [cpu7_pkg::value_w-1:0] alu_res;
	logic push_go;
	logic exec;

	assign push_go = en && cmd.push_en;
	assign exec = en && cmd.instr_en;

	assign top_idx = cpu7_pkg::stack_idx_w'(sp - 1'b1);
	assign sec_idx = cpu7_pkg::stack_idx_w'(sp - 2'd2);
	assign push_idx = cpu7_pkg::stack_idx_w'(sp);
	assign res_idx = (sp >= 2) ? sec_idx : '0; // short stack: result lands at bottom

	// missing operands read as zero
	assign top = (sp >= 1) ? stack[top_idx] : '0;
	assign second = (sp >= 2) ? stack[sec_idx] : '0;

	always_comb begin
		case (cmd.opcode)
			cpu7_pkg::op_add: alu_res = second + top;
			cpu7_pkg::op_sub: alu_res = second - top;
			cpu7_pkg::op_and: alu_res = second & top;
			cpu7_pkg::op_xor: alu_res = second ^ top;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (push_go) begin
			stack[push_idx] <= cmd.push_value;
		end else if (exec) begin
			case (cmd.opcode)
				cpu7_pkg::op_add, cpu7_pkg::op_sub, cpu7_pkg::op_and, cpu7_pkg::op_xor:
					stack[res_idx] <= alu_res;
				cpu7_pkg::op_dup:
					stack[push_idx] <= top;
				cpu7_pkg::op_swap:
					if (sp >= 2) begin // needs two entries, else no change
						stack[top_idx] <= second;
						stack[sec_idx] <= top;
					end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || restart) begin
			pc <= cpu7_pkg::pc_w'(core_index * cpu7_pkg::region_words); // region start
			sp <= '0;
			idle <= 1'b1;
			halted <= 1'b0;
			out_value <= '0;
		end else begin
			idle <= !(push_go || exec); // low for the execute cycle only
			if (en && step)
				pc <= pc + 1'b1;
			if (push_go) begin
				sp <= sp + 1'b1;
			end else if (exec) begin
				case (cmd.opcode)
					cpu7_pkg::op_add, cpu7_pkg::op_sub, cpu7_pkg::op_and, cpu7_pkg::op_xor:
						sp <= (sp >= 2) ? sp - 1'b1 : cpu7_pkg::sp_w'(1);
					cpu7_pkg::op_dup:
						sp <= sp + 1'b1;
					cpu7_pkg::op_drop:
						if (sp != 0)
							sp <= sp - 1'b1;
					cpu7_pkg::op_out:
						out_value <= top; // no pop
					cpu7_pkg::op_halt:
						halted <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/word_sequencer.sv ====
// round-robin word sequencer: fetch, accumulate and dispatch for each core in turn

`default_nettype none

module word_sequencer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire logic [cpu7_pkg::word_w-1:0] rdata,
	output logic [cpu7_pkg::pc_w-1:0] raddr,
	input wire logic [cpu7_pkg::cores-1:0][cpu7_pkg::pc_w-1:0] pcs,
	input wire logic [cpu7_pkg::cores-1:0] idle,
	input wire logic [cpu7_pkg::cores-1:0] halted,
	output logic [cpu7_pkg::cores-1:0] core_sel,
	output logic restart,
	output logic step,
	output cpu7_pkg::core_cmd_t cmd,
	output logic busy,
	output logic done
);

	cpu7_pkg::seq_state_e state;
	cpu7_pkg::word_type_e wtype;
	logic [cpu7_pkg::core_idx_w-1:0] active; // core whose turn it is
	logic [cpu7_pkg::core_idx_w-1:0] next_idx;
	logic [cpu7_pkg::core_idx_w-1:0] cand;
	logic [cpu7_pkg::word_w-1:0] word_q;
	logic [cpu7_pkg::value_w-1:0] accum;
	logic [cpu7_pkg::value_w-1:0] accum_next;
	logic [cpu7_pkg::shift_w-1:0] shift_cnt;
	logic is_data;
	logic turn_end; // last decoded word was dispatched

	assign raddr = pcs[active];
	assign wtype = cpu7_pkg::word_type_e'(word_q[15:14]);
	assign is_data = (wtype == cpu7_pkg::wt_dnl) || (wtype == cpu7_pkg::wt_dat);

	// payload beyond value_w falls off
	assign accum_next = accum | (cpu7_pkg::value_w'(word_q[cpu7_pkg::payload_w-1:0]) << shift_cnt);

	assign restart = (state == cpu7_pkg::s_start);
	assign step = (state == cpu7_pkg::s_decode_word);
	assign core_sel = (state == cpu7_pkg::s_idle || state == cpu7_pkg::s_start) ? '0 :
		cpu7_pkg::cores'(1) << active;

	always_comb begin
		cmd.push_en = (state == cpu7_pkg::s_decode_word) && (wtype == cpu7_pkg::wt_dat);
		cmd.instr_en = (state == cpu7_pkg::s_decode_word) && (wtype == cpu7_pkg::wt_cpu);
		cmd.push_value = accum_next;
		cmd.opcode = cpu7_pkg::opcode_e'(word_q[3:0]);
	end

	// first non-halted core after the active one, wrapping
	always_comb begin
		next_idx = active;
		for (int k = cpu7_pkg::cores; k >= 1; k--) begin
			cand = cpu7_pkg::core_idx_w'((int'(active) + k) % cpu7_pkg::cores);
			if (!halted[cand])
				next_idx = cand;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu7_pkg::s_idle;
			active <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			turn_end <= 1'b0;
		end else begin
			case (state)
				cpu7_pkg::s_idle:
					if (start) begin
						busy <= 1'b1;
						done <= 1'b0;
						state <= cpu7_pkg::s_start;
					end
				cpu7_pkg::s_start: begin
					active <= '0; // cores restart this cycle
					state <= cpu7_pkg::s_before_read;
				end
				cpu7_pkg::s_before_read:
					state <= cpu7_pkg::s_read_word;
				cpu7_pkg::s_read_word:
					state <= cpu7_pkg::s_decode_word;
				cpu7_pkg::s_decode_word: begin
					turn_end <= (wtype == cpu7_pkg::wt_dat) || (wtype == cpu7_pkg::wt_cpu);
					state <= cpu7_pkg::s_wait_core;
				end
				cpu7_pkg::s_wait_core:
					if (idle[active])
						state <= turn_end ? cpu7_pkg::s_next_core : cpu7_pkg::s_read_word;
				cpu7_pkg::s_next_core:
					if (&halted) begin // run finished
						busy <= 1'b0;
						done <= 1'b1;
						state <= cpu7_pkg::s_idle;
					end else begin
						active <= next_idx;
						state <= cpu7_pkg::s_before_read;
					end
				default:
					state <= cpu7_pkg::s_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (state == cpu7_pkg::s_before_read) begin
			accum <= '0;
			shift_cnt <= '0;
		end
		if (state == cpu7_pkg::s_read_word)
			word_q <= rdata;
		if (state == cpu7_pkg::s_decode_word && is_data) begin
			accum <= accum_next;
			if (shift_cnt < cpu7_pkg::value_w) // saturate once past the top
				shift_cnt <= shift_cnt + cpu7_pkg::shift_w'(cpu7_pkg::payload_w);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/apb_host_port.sv ====
// apb slave: program load, run control, status and output register readback

`default_nettype none

module apb_host_port (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu7_pkg::apb_req_t apb_req,
	output cpu7_pkg::apb_rsp_t apb_rsp,
	output logic ram_we,
	output logic [cpu7_pkg::pc_w-1:0] ram_waddr,
	output logic [cpu7_pkg::word_w-1:0] ram_wdata,
	output logic [cpu7_pkg::pc_w-1:0] ram_raddr,
	input wire logic [cpu7_pkg::word_w-1:0] ram_rdata,
	output logic start,
	input wire logic busy,
	input wire logic done,
	input wire logic [cpu7_pkg::cores-1:0] halted,
	input wire logic [cpu7_pkg::cores-1:0][cpu7_pkg::value_w-1:0] out_values
);

	logic access;
	logic is_prog;
	logic is_ctrl;
	logic is_status;
	logic is_out;
	logic err;
	logic [cpu7_pkg::apb_addr_w-1:0] out_offs;

	assign access = apb_req.psel && apb_req.penable;
	assign out_offs = apb_req.paddr - cpu7_pkg::addr_out_base;

	assign is_prog = apb_req.paddr < cpu7_pkg::addr_ctrl;
	assign is_ctrl = apb_req.paddr == cpu7_pkg::addr_ctrl;
	assign is_status = apb_req.paddr == cpu7_pkg::addr_status;
	assign is_out = (apb_req.paddr >= cpu7_pkg::addr_out_base) &&
		(out_offs < cpu7_pkg::apb_addr_w'(4 * cpu7_pkg::cores)) && (apb_req.paddr[1:0] == 2'b00);

	// unmapped, writes to read-only regs, program writes during a run
	assign err = !(is_prog || is_ctrl || is_status || is_out) ||
		(apb_req.pwrite && (is_status || is_out)) ||
		(apb_req.pwrite && is_prog && busy);

	assign ram_we = access && apb_req.pwrite && is_prog && !busy;
	assign ram_waddr = apb_req.paddr[cpu7_pkg::pc_w+1:2];
	assign ram_raddr = apb_req.paddr[cpu7_pkg::pc_w+1:2];
	assign ram_wdata = apb_req.pwdata[cpu7_pkg::word_w-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n)
			start <= 1'b0;
		else
			start <= access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0]; // one cycle
	end

	always_comb begin
		apb_rsp.prdata = '0;
		if (is_prog)
			apb_rsp.prdata = 32'(ram_rdata);
		else if (is_status)
			apb_rsp.prdata = 32'({halted, 2'b00, done, busy});
		else if (is_out)
			apb_rsp.prdata = out_values[out_offs[cpu7_pkg::core_idx_w+1:2]];
		apb_rsp.pready = 1'b1; // no wait states
		apb_rsp.pslverr = access && err;
	end

endmodule

`default_nettype wire

// ==== rtl/cpu7_soc.sv ====
// cpu7 top: program ram, word sequencer, stack cores and apb port

`default_nettype none

module cpu7_soc (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu7_pkg::apb_req_t apb_req,
	output cpu7_pkg::apb_rsp_t apb_rsp
);

	logic ram_we;
	logic [cpu7_pkg::pc_w-1:0] ram_waddr;
	logic [cpu7_pkg::word_w-1:0] ram_wdata;
	logic [cpu7_pkg::pc_w-1:0] host_raddr;
	logic [cpu7_pkg::word_w-1:0] host_rdata;
	logic [cpu7_pkg::pc_w-1:0] seq_raddr;
	logic [cpu7_pkg::word_w-1:0] seq_rdata;
	logic start;
	logic busy;
	logic done;
	logic restart;
	logic step;
	cpu7_pkg::core_cmd_t cmd;
	logic [cpu7_pkg::cores-1:0] core_sel;
	logic [cpu7_pkg::cores-1:0] idle;
	logic [cpu7_pkg::cores-1:0] halted;
	logic [cpu7_pkg::cores-1:0][cpu7_pkg::pc_w-1:0] pcs;
	logic [cpu7_pkg::cores-1:0][cpu7_pkg::value_w-1:0] out_values;

	program_ram i_ram (
		.clk, .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.raddr(seq_raddr), .rdata(seq_rdata),
		.host_raddr, .host_rdata
	);

	word_sequencer i_seq (
		.clk, .rst_n, .start, .rdata(seq_rdata), .raddr(seq_raddr),
		.pcs, .idle, .halted, .core_sel, .restart, .step, .cmd, .busy, .done
	);

	apb_host_port i_apb (
		.clk, .rst_n, .apb_req, .apb_rsp,
		.ram_we, .ram_waddr, .ram_wdata, .ram_raddr(host_raddr), .ram_rdata(host_rdata),
		.start, .busy, .done, .halted, .out_values
	);

	for (genvar i = 0; i < cpu7_pkg::cores; i++) begin : g_core
		stack_core #(.core_index(i)) i_core (
			.clk, .rst_n, .en(core_sel[i]), .restart, .step, .cmd,
			.pc(pcs[i]), .idle(idle[i]), .halted(halted[i]), .out_value(out_values[i])
		);
	end

endmodule

`default_nettype wire

// ==== dv/cpu7_soc_tb.sv ====
// cpu7_soc testbench with apb tasks, program builder, reference model, test table and run loop

`default_nettype none

module cpu7_soc_tb;

	localparam int n_tests = 6;
	localparam int n_cores = 4;
	localparam int region = 64; // words per core region

	logic clk = 1'b0;
	logic rst_n;
	cpu7_pkg::apb_req_t apb_req;
	cpu7_pkg::apb_rsp_t apb_rsp;

	// tags 1 2 3 push over that many data words and i pushes with ignore words inside
	// + - & ^ d x s n o h are add sub and xor dup drop swap nop out halt
	string progs [n_tests][n_cores] = '{
		'{"1oh", "2oh", "3oh", "3o2oh"},
		'{"11+1-1&1^oh", "11-1&1^1+oh", "11&1^1+1-oh", "11^1+1-1&oh"},
		'{"1d+2sxnoh", "12sx1d+n^oh", "2d-1s-2xnoh", "11x3s-d+noh"},
		'{"i1+oh", "ii-oh", "1i^oh", "i2&oh"},
		'{"1oh", "11+1+1+oh", "321++oh", "11-1-1-1-2^oh"},
		'{"2oh", "1h", "11+oh", "3doh"}
	};

	logic [31:0] rng = 32'hffb50031;
	logic [13:0] payloads [$]; // data payloads in build order
	int cycle_count = 0;
	int cycle_limit = 0;
	int errors = 0;
	int test_errors = 0;
	int failed_tests = 0;
	int cur_test = 0;

	cpu7_soc i_dut (
		.clk,
		.rst_n,
		.apb_req,
		.apb_rsp
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: test %0d did not finish within %0d cycles", cur_test, cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int words_of(input byte t);
		case (t)
			"2": return 2;
			"3": return 3;
			"i": return 4; // dnl, two ign, dat
			default: return 1;
		endcase
	endfunction

	function automatic int count_words(input string s);
		int n = 0;
		for (int i = 0; i < s.len(); i++)
			n += words_of(s[i]);
		return n;
	endfunction

	function automatic logic [3:0] tag_opcode(input byte t);
		case (t)
			"+": return cpu7_pkg::op_add;
			"-": return cpu7_pkg::op_sub;
			"&": return cpu7_pkg::op_and;
			"^": return cpu7_pkg::op_xor;
			"d": return cpu7_pkg::op_dup;
			"x": return cpu7_pkg::op_drop;
			"s": return cpu7_pkg::op_swap;
			"o": return cpu7_pkg::op_out;
			"h": return cpu7_pkg::op_halt;
			default: return cpu7_pkg::op_nop;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERROR test %0d %s: got %h expected %h", cur_test, name, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1 err = apb_rsp.pslverr; // before the access edge
		if (apb_rsp.pready !== 1'b1)
			report_mismatch("pready", 32'(apb_rsp.pready), 32'h1);
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		data = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		if (apb_rsp.pready !== 1'b1)
			report_mismatch("pready", 32'(apb_rsp.pready), 32'h1);
		@(negedge clk);
		apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic put_word(input int addr, input logic [15:0] w);
		logic err;
		apb_write(12'(addr * 4), {16'h0, w}, err);
		if (err !== 1'b0)
			report_mismatch($sformatf("pslverr word %0d", addr), 32'(err), 32'h0);
	endtask

	// encode one core's tags into its region
	task automatic build_core(input int core, input string seq);
		int addr;
		int n;
		byte t;
		logic [13:0] p;
		cpu7_pkg::word_type_e wt;
		addr = core * region;
		for (int i = 0; i < seq.len(); i++) begin
			t = seq[i];
			if (t == "i" || (t >= "1" && t <= "3")) begin
				n = (t == "i") ? 2 : int'(t) - 48;
				for (int k = 0; k < n; k++) begin
					rng = lcg(rng);
					p = rng[29:16];
					payloads.push_back(p);
					wt = (k == n - 1) ? cpu7_pkg::wt_dat : cpu7_pkg::wt_dnl;
					put_word(addr, {wt, p});
					addr++;
					if (t == "i" && k == 0) begin // junk payloads the sequencer skips
						rng = lcg(rng);
						put_word(addr, {cpu7_pkg::wt_ign, rng[13:0]});
						put_word(addr + 1, {cpu7_pkg::wt_ign, rng[27:14]});
						addr += 2;
					end
				end
			end else begin
				put_word(addr, {cpu7_pkg::wt_cpu, 10'h0, tag_opcode(t)});
				addr++;
			end
		end
	endtask

	// reference stack machine with empty operands reading as zero
	task automatic model_core(input string seq, output logic [31:0] out_exp,
		output logic halted_exp);
		logic [31:0] stk [$];
		logic [63:0] acc;
		logic [31:0] a;
		logic [31:0] b;
		byte t;
		int n;
		out_exp = '0;
		halted_exp = 1'b0;
		for (int i = 0; i < seq.len() && !halted_exp; i++) begin
			t = seq[i];
			a = (stk.size() > 0) ? stk[$] : '0; // top
			b = (stk.size() > 1) ? stk[$-1] : '0; // second
			case (t)
				"1", "2", "3", "i": begin
					n = (t == "i") ? 2 : int'(t) - 48;
					acc = '0;
					for (int k = 0; k < n; k++)
						acc = acc | (64'(payloads.pop_front()) << (14 * k)); // low word first
					stk.push_back(acc[31:0]);
				end
				"+", "-", "&", "^": begin
					if (stk.size() > 0)
						void'(stk.pop_back());
					if (stk.size() > 0)
						void'(stk.pop_back());
					case (t)
						"+": stk.push_back(b + a);
						"-": stk.push_back(b - a);
						"&": stk.push_back(b & a);
						default: stk.push_back(b ^ a);
					endcase
				end
				"d": stk.push_back(a);
				"x": if (stk.size() > 0) void'(stk.pop_back());
				"s": if (stk.size() > 1) begin
					void'(stk.pop_back());
					void'(stk.pop_back());
					stk.push_back(a);
					stk.push_back(b);
				end
				"o": out_exp = a;
				"h": halted_exp = 1'b1;
				default: ; // nop
			endcase
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		logic [31:0] exp_out [n_cores];
		logic [n_cores-1:0] exp_halted;
		logic h;
		int words;
		int limit;
		apb_req = '0;
		rst_n = 1'b0;
		limit = 0;
		for (int t = 0; t < n_tests; t++) begin
			words = 0;
			for (int c = 0; c < n_cores; c++)
				words += count_words(progs[t][c]);
			limit += words * 6 + 40;
		end
		cycle_limit = 2 * limit;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		apb_read(cpu7_pkg::addr_status, rd, err);
		if (rd[7:0] !== 8'h00)
			report_mismatch("status after reset", rd, 32'h0);

		for (int t = 0; t < n_tests; t++) begin
			cur_test = t;
			test_errors = 0;
			payloads.delete();
			for (int c = 0; c < n_cores; c++)
				build_core(c, progs[t][c]);
			if (t == 0) begin // readback and unmapped write
				put_word(255, 16'h5a3c);
				apb_read(12'h3fc, rd, err);
				if (rd !== 32'h5a3c)
					report_mismatch("prdata word 255", rd, 32'h5a3c);
				apb_write(12'ha00, 32'h1, err);
				if (err !== 1'b1)
					report_mismatch("pslverr unmapped", 32'(err), 32'h1);
			end
			apb_write(cpu7_pkg::addr_ctrl, 32'h1, err);
			if (t == 4) begin // program write during the run
				apb_read(cpu7_pkg::addr_status, rd, err);
				if (rd[0] !== 1'b1)
					report_mismatch("status busy", 32'(rd[0]), 32'h1);
				apb_write(12'h3fc, 32'h0f0f, err);
				if (err !== 1'b1)
					report_mismatch("pslverr busy write", 32'(err), 32'h1);
			end
			rd = '0;
			while (rd[1] !== 1'b1)
				apb_read(cpu7_pkg::addr_status, rd, err);
			for (int c = 0; c < n_cores; c++) begin
				model_core(progs[t][c], exp_out[c], h);
				exp_halted[c] = h;
			end
			if (rd[7:0] !== {exp_halted, 4'b0010}) // done set and busy clear
				report_mismatch("status", 32'(rd[7:0]), 32'({exp_halted, 4'b0010}));
			for (int c = 0; c < n_cores; c++) begin
				apb_read(12'(cpu7_pkg::addr_out_base + 4 * c), rd, err);
				if (rd !== exp_out[c])
					report_mismatch($sformatf("out_value[%0d]", c), rd, exp_out[c]);
			end
			if (t == 4) begin
				apb_read(12'h3fc, rd, err);
				if (rd !== 32'h5a3c)
					report_mismatch("prdata word 255 after busy write", rd, 32'h5a3c);
			end
			if (test_errors == 0) begin
				$display("test %0d: ok", t);
			end else begin
				$display("test %0d: %0d errors", t, test_errors);
				failed_tests++;
			end
		end

		$display("%0d tests, %0d failing, %0d errors", n_tests, failed_tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/cpu7_pkg.sv
rtl/program_ram.sv
rtl/stack_core.sv
rtl/word_sequencer.sv
rtl/apb_host_port.sv
rtl/cpu7_soc.sv
dv/cpu7_soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --top-module cpu7_soc_tb -f project.f -o cpu7_soc_sim
./obj_dir/cpu7_soc_sim > sim.log
cat sim.log
grep -qx "sim passed" sim.log
